// File: vlog.f
src/mmio_pkg.sv
src/mmio_apb_bridge.sv
src/sysinfo_regs.sv
src/sys_timer.sv
src/mmio_top.sv
tests/mmio_assertions.sv
tests/mmio_tb.sv

// File: tests/mmio_tb.sv
/* Testbench for mmio_top; APB inputs change on the falling edge, results sampled at the
   completing rising edge. Assumes the bound assertion module is present in the build. */

`timescale 1ns/1ps

module mmio_tb;

    import mmio_pkg::*;

    logic                   sys_clk;
    logic                   sys_rst_n;
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [mmio_addr_w-1:0] paddr;
    logic [mmio_data_w-1:0] pwdata;
    logic [mmio_data_w-1:0] prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   timer_irq;

    logic [31:0]            lfsr_state;
    int unsigned            check_errors;
    int unsigned            timeout_errors;

    mmio_top UUT (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .timer_irq (timer_irq)
    );

    always #4 sys_clk = ~sys_clk;

    // ============================================================
    // Helpers
    // ============================================================
    // Galois LFSR stepped once per bit taken
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] value;
        logic        lsb;
        value = '0;
        for (int b = 0; b < n; b++) begin
            lsb        = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h8020_0003;
            end
            value = {value[62:0], lsb};
        end
        return value;
    endfunction

    // Mapped nibbles 1 and 3 are moved to the unmapped 5 and 7
    function automatic logic [mmio_addr_w-1:0] pick_unmapped_addr();
        logic [3:0] nib;
        logic [7:0] offset;
        nib    = random_bits(4);
        offset = random_bits(8);
        if (nib == 4'h1 || nib == 4'h3) begin
            nib[2] = 1'b1;
        end
        return {nib, offset};
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            check_errors++;
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic run_transfer(input logic write, input logic [mmio_addr_w-1:0] addr,
                                input logic [mmio_data_w-1:0] data,
                                output logic [mmio_data_w-1:0] rdata, output logic err);
        int waits;
        // Setup phase
        @(negedge sys_clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = data;
        // Access phase completes on the first rising edge with pready
        @(negedge sys_clk);
        penable = 1'b1;
        waits   = 0;
        @(posedge sys_clk);
        while (!pready && waits < 16) begin
            @(posedge sys_clk);
            waits++;
        end
        if (!pready) begin
            timeout_errors++;
            $display("Timeout: pready never rose for the transfer to address %h", addr);
        end
        rdata = prdata;
        err   = pslverr;
        @(negedge sys_clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [mmio_addr_w-1:0] addr,
                             input logic [mmio_data_w-1:0] data, output logic err);
        logic [mmio_data_w-1:0] unused_rdata;
        run_transfer(1'b1, addr, data, unused_rdata, err);
    endtask

    task automatic apb_read(input logic [mmio_addr_w-1:0] addr,
                            output logic [mmio_data_w-1:0] rdata, output logic err);
        run_transfer(1'b0, addr, '0, rdata, err);
    endtask

    task automatic read_and_check(input string name, input logic [mmio_addr_w-1:0] addr,
                                  input logic [mmio_data_w-1:0] expected);
        logic [mmio_data_w-1:0] rdata;
        logic                   err;
        apb_read(addr, rdata, err);
        check_value(name, expected, rdata);
        check_value({name, " pslverr"}, 64'd0, {63'd0, err});
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    initial begin : main
        logic [mmio_data_w-1:0] rdata;
        logic                   err;
        logic [mmio_data_w-1:0] up_first;
        logic [mmio_data_w-1:0] up_second;
        logic [mmio_data_w-1:0] pattern;
        logic [mmio_addr_w-1:0] bad_addr;
        int                     waits;

        sys_clk        = 1'b0;
        sys_rst_n      = 1'b0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        lfsr_state     = 32'hce24;
        check_errors   = 0;
        timeout_errors = 0;

        repeat (10) @(posedge sys_clk);
        @(negedge sys_clk);
        sys_rst_n = 1'b1;

        // System information constants
        read_and_check("info_mem_size", 12'h300, 64'd4194304);
        read_and_check("info_num_cores", 12'h301, 64'd4);
        read_and_check("info_num_clusters", 12'h302, 64'd3);
        read_and_check("info_clock_hz", 12'h303, 64'd100000000);
        read_and_check("info_num_full", 12'h304, 64'd4);
        read_and_check("info_unused_index", 12'h307, 64'd0);

        // Uptime moves forward across other transfers
        apb_read(12'h305, up_first, err);
        read_and_check("info_mem_size between uptime reads", 12'h300, 64'd4194304);
        apb_read(12'h305, up_second, err);
        assert (up_second > up_first) else begin
            check_errors++;
            $display("FAILED info_uptime: expected above %0d, actual %0d",
                     up_first, up_second);
        end

        // Timer compare readback and idle count while disabled
        pattern = random_bits(64);
        apb_write(12'h101, pattern, err);
        read_and_check("timer_compare readback", 12'h101, pattern);
        read_and_check("timer_count disabled first", 12'h100, 64'd0);
        read_and_check("timer_count disabled second", 12'h100, 64'd0);

        // ============================================================
        // Timer match and interrupt
        // ============================================================
        apb_write(12'h101, 64'd12, err);
        apb_write(12'h102, 64'd3, err);
        waits = 0;
        while (!timer_irq && waits < 200) begin
            @(negedge sys_clk);
            waits++;
        end
        if (!timer_irq) begin
            timeout_errors++;
            $display("Timeout: timer_irq did not rise after the compare match");
        end
        read_and_check("timer_status match set", 12'h103, 64'd1);
        apb_write(12'h103, 64'd1, err);
        check_value("timer_irq after clear", 64'd0, {63'd0, timer_irq});
        read_and_check("timer_status cleared", 12'h103, 64'd0);

        // Match with the interrupt enable clear, then toggle the enable
        apb_write(12'h102, 64'd1, err);
        apb_write(12'h100, 64'd0, err);
        rdata = '0;
        waits = 0;
        while (rdata != 64'd1 && waits < 40) begin
            apb_read(12'h103, rdata, err);
            waits++;
        end
        if (rdata != 64'd1) begin
            timeout_errors++;
            $display("Timeout: the match flag did not set with the interrupt enable clear");
        end
        apb_write(12'h102, 64'd3, err);
        check_value("timer_irq after enable", 64'd1, {63'd0, timer_irq});
        apb_write(12'h102, 64'd0, err);
        apb_write(12'h103, 64'd1, err);

        // ============================================================
        // Error responses
        // ============================================================
        for (int i = 0; i < 6; i++) begin
            bad_addr = pick_unmapped_addr();
            pattern  = random_bits(64);
            run_transfer(random_bits(1), bad_addr, pattern, rdata, err);
            check_value("unmapped pslverr", 64'd1, {63'd0, err});
            check_value("unmapped prdata", 64'd0, rdata);
        end
        pattern = random_bits(64);
        run_transfer(1'b1, 12'h301, pattern, rdata, err);
        check_value("sysinfo write pslverr", 64'd1, {63'd0, err});
        check_value("sysinfo write prdata", 64'd0, rdata);
        read_and_check("info_num_cores after write", 12'h301, 64'd4);

        repeat (2) @(posedge sys_clk);
        $display("Errors: %0d check, %0d timeout, %0d assertion",
                 check_errors, timeout_errors, UUT.u_assertions.fail_count);
        if (check_errors == 0 && timeout_errors == 0 &&
            UUT.u_assertions.fail_count == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Overall limit on simulated time
    initial begin : watchdog
        repeat (5000) @(posedge sys_clk);
        $display("Watchdog expired before the test sequence finished");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

// File: tests/mmio_assertions.sv
/* Protocol and response checks for mmio_top, bound into every instance of it.
   Assumes the master follows APB, so pready is expected only in access phases. */

`timescale 1ns/1ps

module mmio_assertions (
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pready,
    input  logic                               pslverr,
    input  logic [mmio_pkg::mmio_data_w-1:0]   prdata,
    input  logic                               timer_irq,
    input  logic                               irq_en
);

    // Read by the testbench for its closing report
    int unsigned fail_count = 0;

    // ============================================================
    // APB handshake
    // ============================================================
    pready_in_access: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n) pready |-> (psel && penable)
    ) else begin
        fail_count++;
        $error("pready high outside an APB access phase");
    end

    pslverr_with_pready: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n) pslverr |-> pready
    ) else begin
        fail_count++;
        $error("pslverr high without pready");
    end

    // ============================================================
    // Response contents
    // ============================================================
    error_data_zero: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n) pslverr |-> (prdata == '0)
    ) else begin
        fail_count++;
        $error("prdata not zero on an error response");
    end

    irq_needs_enable: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n) !irq_en |-> !timer_irq
    ) else begin
        fail_count++;
        $error("timer_irq high with the interrupt enable clear");
    end

endmodule

bind mmio_top mmio_assertions u_assertions (
    .sys_clk   (sys_clk),
    .sys_rst_n (sys_rst_n),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr),
    .prdata    (prdata),
    .timer_irq (timer_irq),
    .irq_en    (u_timer.irq_en_q)
);

// File: src/mmio_top.sv
/* MMIO slice of the SoC: APB bridge, timer at 0x100, system info at 0x300.
   Everything else in the 12-bit space answers with pslverr. */

`timescale 1ns/1ps

module mmio_top (
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,

    // APB slave port
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [mmio_pkg::mmio_addr_w-1:0]   paddr,
    input  logic [mmio_pkg::mmio_data_w-1:0]   pwdata,
    output logic [mmio_pkg::mmio_data_w-1:0]   prdata,
    output logic                               pready,
    output logic                               pslverr,

    // Timer interrupt, level
    output logic                               timer_irq
);

    import mmio_pkg::*;

    // Bridge to peripherals
    logic [reg_idx_w-1:0]   reg_idx;
    logic [mmio_data_w-1:0] wdata;
    logic                   timer_wen;
    logic [mmio_data_w-1:0] timer_rdata;
    logic [mmio_data_w-1:0] info_rdata;

    // ============================================================
    // APB decode and response
    // ============================================================
    mmio_apb_bridge u_bridge (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .reg_idx     (reg_idx),
        .wdata       (wdata),
        .timer_wen   (timer_wen),
        .timer_rdata (timer_rdata),
        .info_rdata  (info_rdata)
    );

    // ============================================================
    // Peripherals
    // ============================================================
    sysinfo_regs u_sysinfo (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .reg_idx    (reg_idx),
        .info_rdata (info_rdata)
    );

    sys_timer u_timer (
        .sys_clk     (sys_clk),
        .sys_rst_n   (sys_rst_n),
        .reg_idx     (reg_idx),
        .wdata       (wdata),
        .timer_wen   (timer_wen),
        .timer_rdata (timer_rdata),
        .timer_irq   (timer_irq)
    );

endmodule

// File: src/sys_timer.sv
/* 64-bit timer with a compare match; count wraps silently at the top.
   timer_irq is a level, held until the match flag is cleared by writing 1. */

`timescale 1ns/1ps

module sys_timer (
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,
    input  logic [mmio_pkg::reg_idx_w-1:0]     reg_idx,
    input  logic [mmio_pkg::mmio_data_w-1:0]   wdata,
    input  logic                               timer_wen,
    output logic [mmio_pkg::mmio_data_w-1:0]   timer_rdata,
    output logic                               timer_irq
);

    import mmio_pkg::*;

    // Register state
    logic [mmio_data_w-1:0] count_q;
    logic [mmio_data_w-1:0] compare_q;
    logic                   cnt_en_q;
    logic                   irq_en_q;
    logic                   match_q;

    // Next-state values
    logic [mmio_data_w-1:0] count_d;
    logic [mmio_data_w-1:0] compare_d;
    logic                   cnt_en_d;
    logic                   irq_en_d;
    logic                   match_d;

    // ============================================================
    // Next-state logic
    // ============================================================
    always_comb begin
        count_d   = count_q;
        compare_d = compare_q;
        cnt_en_d  = cnt_en_q;
        irq_en_d  = irq_en_q;
        match_d   = match_q;

        if (cnt_en_q) begin
            count_d = count_q + 1'b1;
        end

        // A bus write overrides the increment on the same edge
        if (timer_wen) begin
            case (reg_idx)
                timer_count:   count_d   = wdata;
                timer_compare: compare_d = wdata;
                timer_ctrl: begin
                    cnt_en_d = wdata[ctrl_cnt_en_bit];
                    irq_en_d = wdata[ctrl_irq_en_bit];
                end
                timer_status: begin
                    if (wdata[status_match_bit]) begin
                        match_d = 1'b0;
                    end
                end
                default: ;
            endcase
        end

        // A new match wins over a clear in the same cycle
        if (cnt_en_q && (count_q == compare_q)) begin
            match_d = 1'b1;
        end
    end

    // ============================================================
    // Registers
    // ============================================================
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            count_q   <= '0;
            compare_q <= '0;
            cnt_en_q  <= 1'b0;
            irq_en_q  <= 1'b0;
            match_q   <= 1'b0;
            timer_irq <= 1'b0;
        end else begin
            count_q   <= count_d;
            compare_q <= compare_d;
            cnt_en_q  <= cnt_en_d;
            irq_en_q  <= irq_en_d;
            match_q   <= match_d;
            // Built from next-state values so it tracks flag and enable exactly
            timer_irq <= match_d && irq_en_d;
        end
    end

    // ============================================================
    // Read mux
    // ============================================================
    always_comb begin
        timer_rdata = '0;
        case (reg_idx)
            timer_count:   timer_rdata = count_q;
            timer_compare: timer_rdata = compare_q;
            timer_ctrl: begin
                timer_rdata[ctrl_cnt_en_bit] = cnt_en_q;
                timer_rdata[ctrl_irq_en_bit] = irq_en_q;
            end
            timer_status:  timer_rdata[status_match_bit] = match_q;
            default:       timer_rdata = '0;
        endcase
    end

endmodule

// File: src/sysinfo_regs.sv
/* Read-only system information; read data is combinational on reg_idx.
   Uptime is a 64-bit cycle count since the last reset. */

`timescale 1ns/1ps

module sysinfo_regs (
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,
    input  logic [mmio_pkg::reg_idx_w-1:0]     reg_idx,
    output logic [mmio_pkg::mmio_data_w-1:0]   info_rdata
);

    import mmio_pkg::*;

    logic [mmio_data_w-1:0] uptime;

    // ============================================================
    // Uptime counter
    // ============================================================
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            uptime <= '0;
        end else begin
            uptime <= uptime + 1'b1;
        end
    end

    // ============================================================
    // Read mux
    // ============================================================
    always_comb begin
        case (reg_idx)
            info_mem_size:     info_rdata = mem_size_bytes;
            info_num_cores:    info_rdata = num_cores;
            info_num_clusters: info_rdata = num_clusters;
            info_clock_hz:     info_rdata = clock_hz;
            // All cores are full cores in this system
            info_num_full:     info_rdata = num_cores;
            info_uptime:       info_rdata = uptime;
            default:           info_rdata = '0;
        endcase
    end

endmodule

// File: src/mmio_apb_bridge.sv
/* APB slave with no wait states; every transfer takes setup plus one access cycle.
   prdata and pslverr are meaningful only in the completing cycle. */

`timescale 1ns/1ps

module mmio_apb_bridge (
    input  logic                               sys_clk,
    input  logic                               sys_rst_n,

    // APB slave port
    input  logic                               psel,
    input  logic                               penable,
    input  logic                               pwrite,
    input  logic [mmio_pkg::mmio_addr_w-1:0]   paddr,
    input  logic [mmio_pkg::mmio_data_w-1:0]   pwdata,
    output logic [mmio_pkg::mmio_data_w-1:0]   prdata,
    output logic                               pready,
    output logic                               pslverr,

    // Peripheral side
    output logic [mmio_pkg::reg_idx_w-1:0]     reg_idx,
    output logic [mmio_pkg::mmio_data_w-1:0]   wdata,
    output logic                               timer_wen,
    input  logic [mmio_pkg::mmio_data_w-1:0]   timer_rdata,
    input  logic [mmio_pkg::mmio_data_w-1:0]   info_rdata
);

    import mmio_pkg::*;

    mmio_region_e             region;
    logic                     access;
    logic                     decode_err;
    logic [mmio_data_w-1:0]   rd_mux;

    // ============================================================
    // Region decode
    // ============================================================
    // Only the top nibble selects a peripheral, the middle bits are ignored
    always_comb begin
        case (paddr[mmio_addr_w-1 -: region_w])
            region_timer:   region = region_timer;
            region_sysinfo: region = region_sysinfo;
            default:        region = region_none;
        endcase
    end

    // Unmapped space, or a write into the read-only info block
    assign decode_err = (region == region_none) ||
                        ((region == region_sysinfo) && pwrite);

    // ============================================================
    // Handshake
    // ============================================================
    // pready goes high in the cycle right after setup and drops again
    always_ff @(posedge sys_clk) begin
        if (!sys_rst_n) begin
            pready <= 1'b0;
        end else begin
            pready <= psel && !penable;
        end
    end

    // Completing cycle of a transfer
    assign access = psel && penable && pready;

    // One-cycle write strobe, lands on the completing edge
    assign timer_wen = access && pwrite && (region == region_timer);

    // Register index and write data go to both peripherals unqualified
    assign reg_idx = paddr[reg_idx_w-1:0];
    assign wdata   = pwdata;

    // ============================================================
    // Response
    // ============================================================
    always_comb begin
        rd_mux = '0;
        if (!pwrite) begin
            case (region)
                region_timer:   rd_mux = timer_rdata;
                region_sysinfo: rd_mux = info_rdata;
                default:        rd_mux = '0;
            endcase
        end
    end

    // Errors force the data to zero
    assign pslverr = access && decode_err;
    assign prdata  = (access && !decode_err) ? rd_mux : '0;

endmodule

// File: src/mmio_pkg.sv
/* Constants for one fixed system configuration; the modules take no parameters.
   Region codes cover paddr[11:8] only, and unlisted nibbles decode to region_none. */

package mmio_pkg;

    // ============================================================
    // Bus widths
    // ============================================================
    localparam int mmio_addr_w = 12;
    localparam int mmio_data_w = 64;
    localparam int reg_idx_w   = 4;

    // Width of the region field at the top of the address
    localparam int region_w    = 4;

    // ============================================================
    // Address regions
    // ============================================================
    typedef enum logic [region_w-1:0] {
        region_none    = 4'h0,
        region_timer   = 4'h1,
        region_sysinfo = 4'h3
    } mmio_region_e;

    // ============================================================
    // Timer register map
    // ============================================================
    typedef enum logic [reg_idx_w-1:0] {
        timer_count   = 4'd0,
        timer_compare = 4'd1,
        timer_ctrl    = 4'd2,
        timer_status  = 4'd3
    } timer_reg_e;

    // Control and status bit positions
    localparam int ctrl_cnt_en_bit  = 0;
    localparam int ctrl_irq_en_bit  = 1;
    localparam int status_match_bit = 0;

    // ============================================================
    // System information register map
    // ============================================================
    typedef enum logic [reg_idx_w-1:0] {
        info_mem_size     = 4'd0,
        info_num_cores    = 4'd1,
        info_num_clusters = 4'd2,
        info_clock_hz     = 4'd3,
        info_num_full     = 4'd4,
        info_uptime       = 4'd5
    } sysinfo_reg_e;

    // System constants, already sized to the data bus
    localparam logic [mmio_data_w-1:0] mem_size_bytes = 64'd4194304;
    localparam logic [mmio_data_w-1:0] num_cores      = 64'd4;
    localparam logic [mmio_data_w-1:0] num_clusters   = 64'd3;
    localparam logic [mmio_data_w-1:0] clock_hz       = 64'd100000000;

endpackage
